// ==== rtl/rp_consts.svh ====
/*
  shared constants of the scope and generator datapath
  widths, capture depth, register map and reset values
*/

`ifndef RP_CONSTS_SVH
`define RP_CONSTS_SVH

// channel counts and datapath widths
`define RP_CHN        2
`define RP_ADC_DW     16
`define RP_DAC_DW     14
`define RP_LOOP_SHIFT 2
`define RP_PDM_CHN    4
`define RP_PDM_DW     8

// capture depth, 64 samples per channel
`define RP_BUF_AW     6

// wishbone word address and data widths
`define RP_WB_AW      10
`define RP_WB_DW      32

// identification word and DAC midscale code
`define RP_ID         32'h52503031
`define RP_DAC_RST    14'h1fff

// register map, word addresses
`define RP_REG_ID     10'h000
`define RP_REG_LOOP   10'h001
`define RP_REG_ARM    10'h002
`define RP_REG_STATUS 10'h003
`define RP_REG_DAC0   10'h004
`define RP_REG_DAC1   10'h005
`define RP_REG_PDM0   10'h008
`define RP_REG_PDM1   10'h009
`define RP_REG_PDM2   10'h00a
`define RP_REG_PDM3   10'h00b
// capture read windows, low bits give the sample index
`define RP_BUF0_BASE  10'h100
`define RP_BUF1_BASE  10'h200

`endif

// ==== rtl/rp_pkg.sv ====
/*
  datapath and bus types
  sample, DAC code, PDM level and wishbone words
*/

`include "rp_consts.svh"

package rp_pkg;

  // ADC pins carry an offset code with negative slope
  typedef logic        [`RP_ADC_DW-1:0] adc_raw_t;
  // two's complement sample as stored in the capture buffer
  typedef logic signed [`RP_ADC_DW-1:0] sample_t;

  // generator value and DAC pin code
  typedef logic signed [`RP_DAC_DW-1:0] dac_code_t;
  typedef logic        [`RP_DAC_DW-1:0] dac_raw_t;

  typedef logic [`RP_PDM_DW-1:0] pdm_level_t;
  typedef logic [`RP_BUF_AW-1:0] buf_addr_t;

  // wishbone
  typedef logic [`RP_WB_AW-1:0] wb_adr_t;
  typedef logic [`RP_WB_DW-1:0] wb_dat_t;

endpackage

// ==== rtl/adc_frontend.sv ====
/*
  ADC front end
  registers both converter buses, maps the offset code to two's complement
  and swaps in the generator value when loopback is on
*/

`include "rp_consts.svh"

module adc_frontend (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  input  rp_pkg::adc_raw_t      adc_a_dat_i,
  input  rp_pkg::adc_raw_t      adc_b_dat_i,
  input  logic [`RP_CHN-1:0]    loop_sel_i,
  input  rp_pkg::dac_code_t     dac_code_a_i,
  input  rp_pkg::dac_code_t     dac_code_b_i,
  output rp_pkg::sample_t       sample_a_o,
  output rp_pkg::sample_t       sample_b_o
);

  // negative slope: keep sign, flip magnitude bits
  function automatic rp_pkg::sample_t adc_conv(input rp_pkg::adc_raw_t raw);
    return {raw[`RP_ADC_DW-1], ~raw[`RP_ADC_DW-2:0]};
  endfunction

  // generator to sample width
  // sign extend first, then scale up by the loop shift
  function automatic rp_pkg::sample_t loop_conv(input rp_pkg::dac_code_t code);
    return rp_pkg::sample_t'(code) <<< `RP_LOOP_SHIFT;
  endfunction

  //////////////////////////////////////////////////
  // input registers with loopback select
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sample_a_o <= '0;
      sample_b_o <= '0;
    end else begin
      // one cycle from pins or loop bit to sample
      sample_a_o <= loop_sel_i[0] ? loop_conv(dac_code_a_i) : adc_conv(adc_a_dat_i);
      sample_b_o <= loop_sel_i[1] ? loop_conv(dac_code_b_i) : adc_conv(adc_b_dat_i);
    end
  end

endmodule

// ==== rtl/acq_buffer.sv ====
/*
  capture buffer
  an arm pulse stores the next 2**DEPTH_AW samples of both channels,
  software reads them back through a registered port
*/

`include "rp_consts.svh"

module acq_buffer #(
  parameter int unsigned DEPTH_AW = `RP_BUF_AW
) (
  input  logic               adc_clk,
  input  logic               top_rst,
  input  rp_pkg::sample_t    sample_a_i,
  input  rp_pkg::sample_t    sample_b_i,
  input  logic               arm_i,
  input  logic               rd_ch_i,
  input  rp_pkg::buf_addr_t  rd_addr_i,
  output rp_pkg::sample_t    rd_data_o,
  output logic               busy_o,
  output logic               done_o
);

  // one memory per channel
  rp_pkg::sample_t mem_a [2**DEPTH_AW];
  rp_pkg::sample_t mem_b [2**DEPTH_AW];

  // write index, also counts the capture length
  logic [DEPTH_AW-1:0] wr_cnt;

  //////////////////////////////////////////////////
  // capture control
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      wr_cnt <= '0;
    end else if (busy_o) begin
      // arm is ignored here
      wr_cnt <= wr_cnt + 1'b1;
      // last index written, stop
      if (&wr_cnt) begin
        busy_o <= 1'b0;
        done_o <= 1'b1;
      end
    end else if (arm_i) begin
      // fresh capture clears done
      busy_o <= 1'b1;
      done_o <= 1'b0;
      wr_cnt <= '0;
    end
  end

  //////////////////////////////////////////////////
  // sample memories
  //////////////////////////////////////////////////

  // both channels written in the same cycle
  always_ff @(posedge adc_clk) begin
    if (busy_o) begin
      mem_a[wr_cnt] <= sample_a_i;
      mem_b[wr_cnt] <= sample_b_i;
    end
  end

  // registered read, data one cycle after address
  always_ff @(posedge adc_clk) begin
    rd_data_o <= rd_ch_i ? mem_b[rd_addr_i] : mem_a[rd_addr_i];
  end

endmodule

// ==== rtl/dac_backend.sv ====
/*
  DAC back end
  maps signed generator values to the converter's offset code
  and holds midscale while in reset
*/

`include "rp_consts.svh"

module dac_backend (
  input  logic               adc_clk,
  input  logic               top_rst,
  input  rp_pkg::dac_code_t  dac_code_a_i,
  input  rp_pkg::dac_code_t  dac_code_b_i,
  output rp_pkg::dac_raw_t   dac_a_dat_o,
  output rp_pkg::dac_raw_t   dac_b_dat_o
);

  // signed to offset code, negative slope
  // code 0 lands on midscale
  function automatic rp_pkg::dac_raw_t dac_conv(input rp_pkg::dac_code_t code);
    return {code[`RP_DAC_DW-1], ~code[`RP_DAC_DW-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      // converter idles at midscale
      dac_a_dat_o <= `RP_DAC_RST;
      dac_b_dat_o <= `RP_DAC_RST;
    end else begin
      dac_a_dat_o <= dac_conv(dac_code_a_i);
      dac_b_dat_o <= dac_conv(dac_code_b_i);
    end
  end

endmodule

// ==== rtl/pdm_modulator.sv ====
/*
  PDM outputs
  first order modulator per channel, level L gives
  exactly L ones in any 256 consecutive cycles
*/

`include "rp_consts.svh"

module pdm_modulator (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  input  rp_pkg::pdm_level_t [`RP_PDM_CHN-1:0]      level_i,
  output logic               [`RP_PDM_CHN-1:0]      pdm_o
);

  // phase accumulators
  rp_pkg::pdm_level_t [`RP_PDM_CHN-1:0] acc;

  // accumulator plus level, carry in the top bit
  logic [`RP_PDM_DW:0] sum [`RP_PDM_CHN];

  always_comb begin
    for (int i = 0; i < `RP_PDM_CHN; i++) begin
      sum[i] = {1'b0, acc[i]} + {1'b0, level_i[i]};
    end
  end

  //////////////////////////////////////////////////
  // accumulate and register the carry
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc   <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < `RP_PDM_CHN; i++) begin
        acc[i]   <= sum[i][`RP_PDM_DW-1:0];
        // overflow is the output bit
        pdm_o[i] <= sum[i][`RP_PDM_DW];
      end
    end
  end

endmodule

// ==== rtl/rp_regs.sv ====
/*
  register bank, wishbone classic slave
  control registers ack after one cycle, capture window reads after two
*/

`include "rp_consts.svh"

module rp_regs (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  input  logic                                  wb_cyc_i,
  input  logic                                  wb_stb_i,
  input  logic                                  wb_we_i,
  input  rp_pkg::wb_adr_t                       wb_adr_i,
  input  rp_pkg::wb_dat_t                       wb_dat_i,
  output rp_pkg::wb_dat_t                       wb_dat_o,
  output logic                                  wb_ack_o,
  output logic [`RP_CHN-1:0]                    loop_sel_o,
  output rp_pkg::dac_code_t                     dac_code_a_o,
  output rp_pkg::dac_code_t                     dac_code_b_o,
  output rp_pkg::pdm_level_t [`RP_PDM_CHN-1:0]  pdm_level_o,
  output logic                                  arm_o,
  output logic                                  buf_rd_ch_o,
  output rp_pkg::buf_addr_t                     buf_rd_addr_o,
  input  rp_pkg::sample_t                       buf_rd_data_i,
  input  logic                                  busy_i,
  input  logic                                  done_i
);

  // clears the sample index from a window address
  localparam rp_pkg::wb_adr_t buf_idx_mask = rp_pkg::wb_adr_t'((1 << `RP_BUF_AW) - 1);

  logic            wb_req;
  logic            rd_wait;
  logic            buf0_hit;
  logic            buf1_hit;
  rp_pkg::wb_dat_t reg_rd_dat;

  // new strobe, not yet answered
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~rd_wait;

  //////////////////////////////////////////////////
  // window decode, straight to the buffer port
  //////////////////////////////////////////////////

  assign buf0_hit      = (wb_adr_i & ~buf_idx_mask) == `RP_BUF0_BASE;
  assign buf1_hit      = (wb_adr_i & ~buf_idx_mask) == `RP_BUF1_BASE;
  assign buf_rd_ch_o   = buf1_hit;
  assign buf_rd_addr_o = wb_adr_i[`RP_BUF_AW-1:0];

  // register read mux, unmapped reads give 0
  always_comb begin
    case (wb_adr_i)
      `RP_REG_ID:     reg_rd_dat = `RP_ID;
      `RP_REG_LOOP:   reg_rd_dat = rp_pkg::wb_dat_t'(loop_sel_o);
      `RP_REG_STATUS: reg_rd_dat = rp_pkg::wb_dat_t'({done_i, busy_i});
      // DAC codes sign extended
      `RP_REG_DAC0:   reg_rd_dat = rp_pkg::wb_dat_t'(dac_code_a_o);
      `RP_REG_DAC1:   reg_rd_dat = rp_pkg::wb_dat_t'(dac_code_b_o);
      `RP_REG_PDM0:   reg_rd_dat = rp_pkg::wb_dat_t'(pdm_level_o[0]);
      `RP_REG_PDM1:   reg_rd_dat = rp_pkg::wb_dat_t'(pdm_level_o[1]);
      `RP_REG_PDM2:   reg_rd_dat = rp_pkg::wb_dat_t'(pdm_level_o[2]);
      `RP_REG_PDM3:   reg_rd_dat = rp_pkg::wb_dat_t'(pdm_level_o[3]);
      default:        reg_rd_dat = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // ack generation and register writes
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      wb_ack_o     <= 1'b0;
      rd_wait      <= 1'b0;
      arm_o        <= 1'b0;
      loop_sel_o   <= '0;
      dac_code_a_o <= '0;
      dac_code_b_o <= '0;
      pdm_level_o  <= '0;
    end else begin
      // single cycle pulses
      wb_ack_o <= 1'b0;
      arm_o    <= 1'b0;
      if (rd_wait) begin
        // memory data is in, answer now
        rd_wait  <= 1'b0;
        wb_ack_o <= 1'b1;
      end else if (wb_req) begin
        // window read waits one more cycle for the memory
        if (!wb_we_i && (buf0_hit || buf1_hit)) rd_wait <= 1'b1;
        else wb_ack_o <= 1'b1;
        if (wb_we_i) begin
          case (wb_adr_i)
            `RP_REG_LOOP: loop_sel_o     <= wb_dat_i[`RP_CHN-1:0];
            `RP_REG_ARM:  arm_o          <= wb_dat_i[0];
            `RP_REG_DAC0: dac_code_a_o   <= wb_dat_i[`RP_DAC_DW-1:0];
            `RP_REG_DAC1: dac_code_b_o   <= wb_dat_i[`RP_DAC_DW-1:0];
            `RP_REG_PDM0: pdm_level_o[0] <= wb_dat_i[`RP_PDM_DW-1:0];
            `RP_REG_PDM1: pdm_level_o[1] <= wb_dat_i[`RP_PDM_DW-1:0];
            `RP_REG_PDM2: pdm_level_o[2] <= wb_dat_i[`RP_PDM_DW-1:0];
            `RP_REG_PDM3: pdm_level_o[3] <= wb_dat_i[`RP_PDM_DW-1:0];
            default: ;
          endcase
        end
      end
    end
  end

  // read data, sample sign extended to the bus width
  always_ff @(posedge adc_clk) begin
    if (rd_wait) wb_dat_o <= rp_pkg::wb_dat_t'(buf_rd_data_i);
    else if (wb_req && !wb_we_i) wb_dat_o <= reg_rd_dat;
  end

endmodule

// ==== rtl/rp_top.sv ====
/*
  scope and generator datapath top
  ADC front end into the capture buffer, DAC and PDM outputs,
  all set up through one wishbone register bank
*/

`include "rp_consts.svh"

module rp_top (
  input  logic                        adc_clk,
  input  logic                        top_rst,
  // ADC pins
  input  rp_pkg::adc_raw_t            adc_a_dat_i,
  input  rp_pkg::adc_raw_t            adc_b_dat_i,
  // wishbone slave
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  rp_pkg::wb_adr_t             wb_adr_i,
  input  rp_pkg::wb_dat_t             wb_dat_i,
  output rp_pkg::wb_dat_t             wb_dat_o,
  output logic                        wb_ack_o,
  // DAC pins
  output rp_pkg::dac_raw_t            dac_a_dat_o,
  output rp_pkg::dac_raw_t            dac_b_dat_o,
  // 1-bit PDM outputs
  output logic [`RP_PDM_CHN-1:0]      pdm_o
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // control from the register bank
  logic [`RP_CHN-1:0]                    loop_sel;
  rp_pkg::dac_code_t                     dac_code_a;
  rp_pkg::dac_code_t                     dac_code_b;
  rp_pkg::pdm_level_t [`RP_PDM_CHN-1:0]  pdm_level;
  logic                                  arm;
  // sample streams, always valid
  rp_pkg::sample_t                       sample_a;
  rp_pkg::sample_t                       sample_b;
  // buffer read port and status
  logic                                  buf_rd_ch;
  rp_pkg::buf_addr_t                     buf_rd_addr;
  rp_pkg::sample_t                       buf_rd_data;
  logic                                  busy;
  logic                                  done;

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  adc_frontend adc_frontend (
    .adc_clk (adc_clk), .top_rst (top_rst),
    .adc_a_dat_i (adc_a_dat_i), .adc_b_dat_i (adc_b_dat_i),
    .loop_sel_i (loop_sel),
    .dac_code_a_i (dac_code_a), .dac_code_b_i (dac_code_b),
    .sample_a_o (sample_a), .sample_b_o (sample_b)
  );

  acq_buffer #(.DEPTH_AW (`RP_BUF_AW)) acq_buffer (
    .adc_clk (adc_clk), .top_rst (top_rst),
    .sample_a_i (sample_a), .sample_b_i (sample_b),
    .arm_i (arm), .rd_ch_i (buf_rd_ch), .rd_addr_i (buf_rd_addr),
    .rd_data_o (buf_rd_data), .busy_o (busy), .done_o (done)
  );

  dac_backend dac_backend (
    .adc_clk (adc_clk), .top_rst (top_rst),
    .dac_code_a_i (dac_code_a), .dac_code_b_i (dac_code_b),
    .dac_a_dat_o (dac_a_dat_o), .dac_b_dat_o (dac_b_dat_o)
  );

  pdm_modulator pdm_modulator (
    .adc_clk (adc_clk), .top_rst (top_rst),
    .level_i (pdm_level), .pdm_o (pdm_o)
  );

  // register bank
  rp_regs rp_regs (
    .adc_clk (adc_clk), .top_rst (top_rst),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
    .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
    .loop_sel_o (loop_sel), .dac_code_a_o (dac_code_a), .dac_code_b_o (dac_code_b),
    .pdm_level_o (pdm_level), .arm_o (arm),
    .buf_rd_ch_o (buf_rd_ch), .buf_rd_addr_o (buf_rd_addr), .buf_rd_data_i (buf_rd_data),
    .busy_i (busy), .done_i (done)
  );

endmodule

// ==== verif/rp_ref.svh ====
/*
  reference models for the datapath testbench
  converter codes, loopback scaling, sign extension and PDM ones count
*/

`ifndef RP_REF_SVH
`define RP_REF_SVH

// ADC pin code to sample, negative slope below the sign bit
function automatic rp_pkg::sample_t ref_adc_conv(input rp_pkg::adc_raw_t pin);
  rp_pkg::adc_raw_t mag_mask;
  mag_mask = {1'b0, {(`RP_ADC_DW-1){1'b1}}};
  return rp_pkg::sample_t'(pin ^ mag_mask);
endfunction

// same map backwards, sample to pin code
function automatic rp_pkg::adc_raw_t ref_adc_pin(input rp_pkg::sample_t smp);
  rp_pkg::adc_raw_t mag_mask;
  mag_mask = {1'b0, {(`RP_ADC_DW-1){1'b1}}};
  return rp_pkg::adc_raw_t'(smp) ^ mag_mask;
endfunction

// signed generator value to DAC pin code, zero lands on midscale
function automatic rp_pkg::dac_raw_t ref_dac_conv(input rp_pkg::dac_code_t code);
  rp_pkg::dac_raw_t mag_mask;
  mag_mask = {1'b0, {(`RP_DAC_DW-1){1'b1}}};
  return rp_pkg::dac_raw_t'(code) ^ mag_mask;
endfunction

// generator value scaled up to sample width
function automatic rp_pkg::sample_t ref_loop(input rp_pkg::dac_code_t code);
  int val;
  val = code;
  val = val * (1 << `RP_LOOP_SHIFT);
  return rp_pkg::sample_t'(val);
endfunction

// sign extension of the low width bits to a bus word
function automatic logic [31:0] ref_sext(input logic [31:0] val, input int width);
  logic signed [31:0] t;
  t = val << (32 - width);
  return t >>> (32 - width);
endfunction

// first order accumulator, counts carries over a window
function automatic int ref_pdm_ones(input rp_pkg::pdm_level_t level, input int cycles);
  int acc;
  int ones;
  acc = 0;
  ones = 0;
  for (int i = 0; i < cycles; i++) begin
    acc = acc + level;
    if (acc >= (1 << `RP_PDM_DW)) begin
      acc = acc - (1 << `RP_PDM_DW);
      ones++;
    end
  end
  return ones;
endfunction

`endif

// ==== verif/tb_rp_top.sv ====
/*
  testbench for the scope and generator datapath
  ADC ramps and wishbone traffic in, DAC pins, captures and PDM bits checked
*/

`include "rp_consts.svh"

module tb_rp_top;

  `include "rp_ref.svh"

  localparam int CLK_PERIOD = 4;
  localparam int ACK_LIMIT  = 8;
  // request, ack and release of one access
  localparam int WB_CYCLES  = ACK_LIMIT + 2;
  localparam int POLL_LIMIT = 64;
  localparam int BUF_DEPTH  = 1 << `RP_BUF_AW;
  // worst case per test: reset, dac, capture, loopback, pdm, rearm, then flushes
  localparam int TEST_CYCLES =
    10 + 2 * WB_CYCLES +
    4 * (4 * WB_CYCLES + 2) +
    (1 + POLL_LIMIT + 2 * BUF_DEPTH) * WB_CYCLES + 1 +
    (3 + POLL_LIMIT + 2 * BUF_DEPTH) * WB_CYCLES + 1 +
    4 * WB_CYCLES + 258 +
    (6 + POLL_LIMIT + BUF_DEPTH) * WB_CYCLES + 1 +
    6 * 2;

  logic                   adc_clk;
  logic                   top_rst;
  rp_pkg::adc_raw_t       adc_a_dat;
  rp_pkg::adc_raw_t       adc_b_dat;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  rp_pkg::wb_adr_t        wb_adr;
  rp_pkg::wb_dat_t        wb_wdat;
  rp_pkg::wb_dat_t        wb_rdat;
  logic                   wb_ack;
  rp_pkg::dac_raw_t       dac_a_dat;
  rp_pkg::dac_raw_t       dac_b_dat;
  logic [`RP_PDM_CHN-1:0] pdm;

  integer           seed = 21070;
  int               chk_cnt = 0;
  int               err_cnt = 0;
  // fixed distance between the two ramps
  rp_pkg::adc_raw_t b_offset;

  // pending checks, stimulus fills, comparator drains
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  rp_top UUT (
    .adc_clk (adc_clk), .top_rst (top_rst),
    .adc_a_dat_i (adc_a_dat), .adc_b_dat_i (adc_b_dat),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
    .wb_adr_i (wb_adr), .wb_dat_i (wb_wdat),
    .wb_dat_o (wb_rdat), .wb_ack_o (wb_ack),
    .dac_a_dat_o (dac_a_dat), .dac_b_dat_o (dac_b_dat),
    .pdm_o (pdm)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  // ADC ramps, one code step per cycle
  initial begin
    adc_a_dat = rp_pkg::adc_raw_t'($random(seed));
    adc_b_dat = rp_pkg::adc_raw_t'($random(seed));
    b_offset  = adc_b_dat - adc_a_dat;
    forever begin
      @(posedge adc_clk);
      adc_a_dat <= adc_a_dat + 1'b1;
      adc_b_dat <= adc_b_dat + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // comparator
  //////////////////////////////////////////////////

  // outputs are settled at the falling edge
  always @(negedge adc_clk) begin
    while (exp_q.size() > 0) begin
      chk_cnt++;
      assert (act_q[0] === exp_q[0])
        else begin
          err_cnt++;
          $display("ERR %s expected %h actual %h", name_q[0], exp_q[0], act_q[0]);
        end
      name_q.delete(0);
      exp_q.delete(0);
      act_q.delete(0);
    end
  end

  task automatic expect_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  // failures with no value to compare
  task automatic report_failure(input string what);
    err_cnt++;
    $display("%s", what);
  endtask

  //////////////////////////////////////////////////
  // wishbone master
  //////////////////////////////////////////////////

  task automatic wb_access(input logic we, input rp_pkg::wb_adr_t adr,
                           input rp_pkg::wb_dat_t wdat, output rp_pkg::wb_dat_t rdat);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_wdat <= wdat;
    // ack and read data taken on the falling edge
    do begin
      @(negedge adc_clk);
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    rdat = wb_rdat;
    if (!wb_ack) report_failure($sformatf("no ack from address %h", adr));
    // strobe drops in the cycle after ack
    @(posedge adc_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input rp_pkg::wb_adr_t adr, input rp_pkg::wb_dat_t dat);
    rp_pkg::wb_dat_t ignored;
    wb_access(1'b1, adr, dat, ignored);
  endtask

  task automatic wb_read(input rp_pkg::wb_adr_t adr, output rp_pkg::wb_dat_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  //////////////////////////////////////////////////
  // capture helpers
  //////////////////////////////////////////////////

  // entry 0 holds the pin code present one cycle before busy
  task automatic arm_capture(output rp_pkg::adc_raw_t arm_pin);
    wb_write(`RP_REG_ARM, 32'h1);
    @(negedge adc_clk);
    arm_pin = adc_a_dat - 1'b1;
  endtask

  task automatic wait_done(input string tag);
    rp_pkg::wb_dat_t st;
    int polls;
    polls = 0;
    do begin
      wb_read(`RP_REG_STATUS, st);
      polls++;
    end while (!st[1] && polls < POLL_LIMIT);
    if (!st[1]) report_failure({tag, ": capture never reported done"});
  endtask

  // whole window must follow consecutive pin codes from entry 0
  task automatic check_ramp(input string tag, input rp_pkg::wb_adr_t base,
                            output rp_pkg::adc_raw_t pin0);
    rp_pkg::wb_dat_t  d;
    rp_pkg::adc_raw_t pin;
    wb_read(base, d);
    pin0 = ref_adc_pin(rp_pkg::sample_t'(d[`RP_ADC_DW-1:0]));
    for (int k = 0; k < BUF_DEPTH; k++) begin
      wb_read(base | rp_pkg::wb_adr_t'(k), d);
      pin = pin0 + rp_pkg::adc_raw_t'(k);
      expect_value($sformatf("%s[%0d]", tag, k), ref_sext(ref_adc_conv(pin), `RP_ADC_DW), d);
    end
  endtask

  // drain the comparator, then one line for the test
  task automatic finish_test(input string name, input int err_start);
    @(negedge adc_clk);
    @(posedge adc_clk);
    $display("test %-9s %s, %0d errors", name,
             (err_cnt == err_start) ? "ok" : "FAILED", err_cnt - err_start);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    rp_pkg::wb_dat_t    rd;
    rp_pkg::dac_code_t  code_a;
    rp_pkg::dac_code_t  code_b;
    rp_pkg::adc_raw_t   arm_pin;
    rp_pkg::adc_raw_t   pin_a;
    rp_pkg::adc_raw_t   pin_b;
    rp_pkg::adc_raw_t   pin_exp;
    rp_pkg::pdm_level_t lvl [`RP_PDM_CHN];
    int                 ones [`RP_PDM_CHN];
    int                 start;
    top_rst = 1'b1;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    repeat (10) @(posedge adc_clk);
    top_rst <= 1'b0;

    // reset values and identification
    start = err_cnt;
    @(negedge adc_clk);
    expect_value("reset dac a", `RP_DAC_RST, dac_a_dat);
    expect_value("reset dac b", `RP_DAC_RST, dac_b_dat);
    expect_value("reset pdm", 32'h0, pdm);
    wb_read(`RP_REG_ID, rd);
    expect_value("id", `RP_ID, rd);
    wb_read(`RP_REG_STATUS, rd);
    expect_value("reset status", 32'h0, rd);
    finish_test("reset", start);

    // DAC pins two cycles after each write, then readback
    start = err_cnt;
    for (int i = 0; i < 4; i++) begin
      code_a = rp_pkg::dac_code_t'($random(seed));
      code_b = rp_pkg::dac_code_t'($random(seed));
      wb_write(`RP_REG_DAC0, ref_sext(code_a, `RP_DAC_DW));
      @(negedge adc_clk);
      expect_value("dac a pins", ref_dac_conv(code_a), dac_a_dat);
      wb_write(`RP_REG_DAC1, ref_sext(code_b, `RP_DAC_DW));
      @(negedge adc_clk);
      expect_value("dac b pins", ref_dac_conv(code_b), dac_b_dat);
      wb_read(`RP_REG_DAC0, rd);
      expect_value("dac a readback", ref_sext(code_a, `RP_DAC_DW), rd);
      wb_read(`RP_REG_DAC1, rd);
      expect_value("dac b readback", ref_sext(code_b, `RP_DAC_DW), rd);
    end
    finish_test("dac", start);

    // ramp capture on both channels
    start = err_cnt;
    arm_capture(arm_pin);
    wait_done("capture");
    check_ramp("capture a", `RP_BUF0_BASE, pin_a);
    check_ramp("capture b", `RP_BUF1_BASE, pin_b);
    pin_exp = arm_pin + b_offset;
    expect_value("capture a start", arm_pin, pin_a);
    expect_value("capture b start", pin_exp, pin_b);
    finish_test("capture", start);

    // generator looped into channel 0 only
    start = err_cnt;
    code_a = rp_pkg::dac_code_t'($random(seed));
    wb_write(`RP_REG_DAC0, ref_sext(code_a, `RP_DAC_DW));
    wb_write(`RP_REG_LOOP, 32'h1);
    arm_capture(arm_pin);
    wait_done("loopback");
    for (int k = 0; k < BUF_DEPTH; k++) begin
      wb_read(`RP_BUF0_BASE | rp_pkg::wb_adr_t'(k), rd);
      expect_value($sformatf("loop a[%0d]", k), ref_sext(ref_loop(code_a), `RP_ADC_DW), rd);
    end
    check_ramp("loop b", `RP_BUF1_BASE, pin_b);
    pin_exp = arm_pin + b_offset;
    expect_value("loop b start", pin_exp, pin_b);
    wb_write(`RP_REG_LOOP, 32'h0);
    finish_test("loopback", start);

    // ones per 256 cycles equal the level
    start = err_cnt;
    for (int c = 0; c < `RP_PDM_CHN; c++) begin
      lvl[c]  = rp_pkg::pdm_level_t'($random(seed));
      ones[c] = 0;
      wb_write(rp_pkg::wb_adr_t'(`RP_REG_PDM0 + c), rp_pkg::wb_dat_t'(lvl[c]));
    end
    // settling cycle
    @(posedge adc_clk);
    repeat (256) begin
      @(negedge adc_clk);
      for (int c = 0; c < `RP_PDM_CHN; c++) ones[c] = ones[c] + int'(pdm[c]);
    end
    for (int c = 0; c < `RP_PDM_CHN; c++) begin
      expect_value($sformatf("pdm%0d ones", c), ref_pdm_ones(lvl[c], 256), ones[c]);
    end
    finish_test("pdm", start);

    // second arm lands mid capture and must not restart it
    start = err_cnt;
    arm_capture(arm_pin);
    wb_read(`RP_REG_STATUS, rd);
    expect_value("rearm busy", 32'h1, rd);
    wb_write(`RP_REG_ARM, 32'h1);
    wait_done("rearm");
    repeat (3) begin
      wb_read(`RP_REG_STATUS, rd);
      expect_value("rearm done", 32'h2, rd);
    end
    check_ramp("rearm a", `RP_BUF0_BASE, pin_a);
    expect_value("rearm start", arm_pin, pin_a);
    finish_test("rearm", start);

    $display("tests 6, checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TEST_CYCLES * CLK_PERIOD);
    $display("timeout, the tests did not finish within %0d cycles", TEST_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
+incdir+verif
rtl/rp_pkg.sv
rtl/adc_frontend.sv
rtl/acq_buffer.sv
rtl/dac_backend.sv
rtl/pdm_modulator.sv
rtl/rp_regs.sv
rtl/rp_top.sv
verif/tb_rp_top.sv

// ==== Makefile ====
# Verilator build and run of tb_rp_top

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_rp_top, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rp_top \
		-f verilog.f -Mdir obj_dir
	./obj_dir/Vtb_rp_top > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
